// File: verilog/lce_resp_wh_consts.svh
// ----------------------------------------------------------------------
// Widths and mesh dimensions for the LCE response wormhole transmitter
// Mesh dimensions must be powers of two for the id to cord mapping
// Payloads above 32 bytes are not supported
// ----------------------------------------------------------------------
`ifndef LCE_RESP_WH_CONSTS_SVH
`define LCE_RESP_WH_CONSTS_SVH

// Cache engine ids
`define LCE_ID_WIDTH 4
`define CCE_ID_WIDTH 4

`define PADDR_WIDTH 32
`define BLOCK_WIDTH 256  // Largest writeback is 32 bytes

// Mesh of 4 by 2 routers, x uses 2 bits and y uses 1 bit
`define NOC_X_DIM 4
`define NOC_Y_DIM 2

// Cord holds a y field above an x field of equal width
`define NOC_CORD_WIDTH 6
`define NOC_CORD_DIM_WIDTH (`NOC_CORD_WIDTH / 2)

`define NOC_CID_WIDTH 2
`define NOC_LEN_WIDTH 4  // Flits after the first one

`define FLIT_WIDTH 64

`endif

// File: verilog/lce_resp_wh_pkg.sv
// ----------------------------------------------------------------------
// Types shared by the response transmitter
// Packed structs list fields from the most significant bit down
// ----------------------------------------------------------------------
`default_nettype none

`include "lce_resp_wh_consts.svh"

package lce_resp_pkg;

  // Response message classes
  typedef enum logic [2:0] {
    e_sync_ack = 3'd0,
    e_inv_ack  = 3'd1,
    e_coh_ack  = 3'd2,
    e_wb       = 3'd3,
    e_null_wb  = 3'd4
  } resp_msg_type_e;

  // Data size in bytes, only meaningful for a writeback
  typedef enum logic [2:0] {
    e_size_1  = 3'd0,
    e_size_2  = 3'd1,
    e_size_4  = 3'd2,
    e_size_8  = 3'd3,
    e_size_16 = 3'd4,
    e_size_32 = 3'd5
  } msg_size_e;

  // ----------------------------------------------------------------------
  // Response message from the cache engine
  // ----------------------------------------------------------------------
  typedef struct packed {
    resp_msg_type_e                  msg_type;
    msg_size_e                       size;
    logic [`PADDR_WIDTH-1:0]         addr;
    logic [`LCE_ID_WIDTH-1:0]        src_id;
    logic [`CCE_ID_WIDTH-1:0]        dst_id;
  } lce_resp_hdr_s;  // 46 bits

  typedef struct packed {
    logic [`BLOCK_WIDTH-1:0] data;
    lce_resp_hdr_s           hdr;
  } lce_resp_msg_s;

  // ----------------------------------------------------------------------
  // Wormhole packet
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [`NOC_CORD_DIM_WIDTH-1:0] y;
    logic [`NOC_CORD_DIM_WIDTH-1:0] x;
  } wh_cord_s;

  typedef struct packed {
    logic [`NOC_CID_WIDTH-1:0] cid;
    logic [`NOC_LEN_WIDTH-1:0] len;
    wh_cord_s                  cord;  // Routed on first, so it sits lowest
  } wh_hdr_s;  // 12 bits

  // Flit 0 starts with the wormhole header and then the message header
  typedef struct packed {
    logic [`BLOCK_WIDTH-1:0] data;
    lce_resp_hdr_s           msg_hdr;
    wh_hdr_s                 wh_hdr;
  } wh_packet_s;

endpackage

`default_nettype wire

// File: verilog/wh_pipe_reg.sv
// ----------------------------------------------------------------------
// Single entry valid/ready register stage for any packed payload
// Ready depends on ready_i in the same cycle, so a chain of these is
// fully pipelined but carries a combinational ready path
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module wh_pipe_reg #(
  parameter type payload_t = logic [7:0]
) (
  input  wire      clk_i,
  input  wire      arst_n_i,
  // Upstream side
  input  wire      v_i,
  input  payload_t data_i,
  output logic     ready_o,
  // Downstream side
  output logic     v_o,
  output payload_t data_o,
  input  wire      ready_i
);

  logic     full_q;
  payload_t data_q;

  // Free slot, or the held item leaves on this edge
  assign ready_o = ~full_q | ready_i;
  assign v_o     = full_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      full_q <= v_i;  // Drains to empty when nothing new arrives
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && ready_o) begin
      data_q <= data_i;
    end
  end

  // A stalled item must not change under the consumer
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (v_o && !ready_i) |=> (v_o && $stable(data_o)));

endmodule

`default_nettype wire

// File: verilog/lce_resp_wh_encode.sv
// ----------------------------------------------------------------------
// Forms a wormhole packet from an LCE response, purely combinational
// Valid and ready pass straight through
// Sizes above 32 bytes and non power of two mesh sizes are unsupported
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

`include "lce_resp_wh_consts.svh"

module lce_resp_wh_encode (
  input  wire                        v_i,
  input  lce_resp_pkg::lce_resp_msg_s msg_i,
  output logic                       ready_o,
  output logic                       v_o,
  output lce_resp_pkg::wh_packet_s   pkt_o,
  input  wire                        ready_i
);

  import lce_resp_pkg::*;

  localparam int HDR_WIDTH  = $bits(wh_hdr_s) + $bits(lce_resp_hdr_s);
  localparam int BITS_WIDTH = $clog2(`BLOCK_WIDTH + 1);

  // Flits after the first for a given number of payload bits
  function automatic logic [`NOC_LEN_WIDTH-1:0] flit_len(input logic [BITS_WIDTH-1:0] bits);
    int unsigned total;
    total = HDR_WIDTH + bits;
    return `NOC_LEN_WIDTH'((total + `FLIT_WIDTH - 1) / `FLIT_WIDTH - 1);
  endfunction

  logic [`CCE_ID_WIDTH-1:0] dst_id;
  wh_cord_s                 cord;
  logic [`NOC_CID_WIDTH-1:0] cid;
  logic [BITS_WIDTH-1:0]    data_bits;  // Payload bits actually carried
  logic [`BLOCK_WIDTH-1:0]  data_mask;

  assign v_o     = v_i;
  assign ready_o = ready_i;

  // ----------------------------------------------------------------------
  // Destination id to mesh position
  // ----------------------------------------------------------------------
  assign dst_id = msg_i.hdr.dst_id;
  assign cord.x = `NOC_CORD_DIM_WIDTH'(dst_id % `NOC_X_DIM);
  assign cord.y = `NOC_CORD_DIM_WIDTH'((dst_id / `NOC_X_DIM) % `NOC_Y_DIM);
  assign cid    = `NOC_CID_WIDTH'(dst_id / (`NOC_X_DIM * `NOC_Y_DIM));

  always_comb begin
    data_bits = '0;
    unique case (msg_i.hdr.msg_type)
      // Acks and null writebacks carry only the header
      e_sync_ack, e_inv_ack, e_coh_ack, e_null_wb: data_bits = '0;
      e_wb: begin
        unique case (msg_i.hdr.size)
          e_size_1:  data_bits = BITS_WIDTH'(8);
          e_size_2:  data_bits = BITS_WIDTH'(16);
          e_size_4:  data_bits = BITS_WIDTH'(32);
          e_size_8:  data_bits = BITS_WIDTH'(64);
          e_size_16: data_bits = BITS_WIDTH'(128);
          e_size_32: data_bits = BITS_WIDTH'(256);
          default:   data_bits = '0;
        endcase
      end
      default: data_bits = '0;
    endcase
  end

  // Full shift yields all ones for a 32 byte block
  assign data_mask = ~({`BLOCK_WIDTH{1'b1}} << data_bits);

  always_comb begin
    pkt_o             = '0;
    pkt_o.wh_hdr.cord = cord;
    pkt_o.wh_hdr.cid  = cid;
    pkt_o.wh_hdr.len  = flit_len(data_bits);
    pkt_o.msg_hdr     = msg_i.hdr;
    pkt_o.data        = msg_i.data & data_mask;  // Stale bytes never reach the NoC
  end

  // The cache engine must never send an encoding outside the size list
  always_comb begin
    if (v_i && msg_i.hdr.msg_type == e_wb) begin
      a_wb_size: assert (msg_i.hdr.size <= e_size_32)
        else $error("writeback with illegal size %0d", msg_i.hdr.size);
    end
  end

endmodule

`default_nettype wire

// File: verilog/wh_flit_serializer.sv
// ----------------------------------------------------------------------
// Sends a held packet as len+1 flits of FLIT_WIDTH bits, lowest first
// A new packet is taken on the edge where the last flit transfers
// The last flit is padded with zeros
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

`include "lce_resp_wh_consts.svh"

module wh_flit_serializer (
  input  wire                            clk_i,
  input  wire                            arst_n_i,
  // Packet in
  input  wire                            v_i,
  input  lce_resp_pkg::wh_packet_s       pkt_i,
  output logic                           ready_o,
  // Flits out
  output logic                           flit_v_o,
  output logic [`FLIT_WIDTH-1:0]         flit_o,
  input  wire                            flit_ready_i
);

  import lce_resp_pkg::*;

  localparam int PKT_WIDTH = $bits(wh_packet_s);
  localparam int NUM_FLITS = (PKT_WIDTH + `FLIT_WIDTH - 1) / `FLIT_WIDTH;
  localparam int PAD_WIDTH = NUM_FLITS * `FLIT_WIDTH;
  localparam int IDX_WIDTH = $clog2(NUM_FLITS);

  logic                       busy_q;
  logic [`NOC_LEN_WIDTH-1:0]  cnt_q;   // Index of the flit on the line
  logic [`NOC_LEN_WIDTH-1:0]  len_q;
  wh_packet_s                 pkt_q;
  logic                       last;
  logic [NUM_FLITS-1:0][`FLIT_WIDTH-1:0] flits;

  assign last     = (cnt_q == len_q);
  assign flit_v_o = busy_q;
  assign ready_o  = ~busy_q | (flit_ready_i & last);

  // ----------------------------------------------------------------------
  // Flit select
  // ----------------------------------------------------------------------
  assign flits  = PAD_WIDTH'(pkt_q);
  assign flit_o = flits[cnt_q[IDX_WIDTH-1:0]];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      len_q  <= '0;
    end else if (ready_o) begin
      busy_q <= v_i;
      cnt_q  <= '0;
      if (v_i) begin
        len_q <= pkt_i.wh_hdr.len;
      end
    end else if (flit_v_o && flit_ready_i) begin
      cnt_q <= cnt_q + 1'b1;  // Not the last flit, so hold the packet
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && ready_o) begin
      pkt_q <= pkt_i;
    end
  end

  // Overrunning len would send flits that belong to no packet
  a_cnt_in_len: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    busy_q |-> (cnt_q <= len_q));

endmodule

`default_nettype wire

// File: verilog/lce_resp_wh_tx.sv
// ----------------------------------------------------------------------
// LCE response transmit path onto a wormhole mesh link
// Message register, encoder, packet register and flit serializer
// Up to three messages in flight, flit 0 first transfers three
// cycles after the input handshake when the output is ready
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

`include "lce_resp_wh_consts.svh"

module lce_resp_wh_tx (
  input  wire                         clk_i,
  input  wire                         arst_n_i,
  input  wire                         msg_v_i,
  input  lce_resp_pkg::lce_resp_msg_s msg_i,
  output logic                        msg_ready_o,
  output logic                        flit_v_o,
  output logic [`FLIT_WIDTH-1:0]      flit_o,
  input  wire                         flit_ready_i
);

  import lce_resp_pkg::*;

  // Stage links, named after the stage that drives valid
  logic          msg_v, msg_ready;
  lce_resp_msg_s msg_q;
  logic          enc_v, enc_ready;
  wh_packet_s    enc_pkt;
  logic          pkt_v, pkt_ready;
  wh_packet_s    pkt_q;

  wh_pipe_reg #(.payload_t(lce_resp_msg_s)) u_msg_reg (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .v_i     (msg_v_i),
    .data_i  (msg_i),
    .ready_o (msg_ready_o),
    .v_o     (msg_v),
    .data_o  (msg_q),
    .ready_i (msg_ready)
  );

  lce_resp_wh_encode u_encode (
    .v_i    (msg_v),
    .msg_i  (msg_q),
    .ready_o(msg_ready),
    .v_o    (enc_v),
    .pkt_o  (enc_pkt),
    .ready_i(enc_ready)
  );

  wh_pipe_reg #(.payload_t(wh_packet_s)) u_pkt_reg (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .v_i     (enc_v),
    .data_i  (enc_pkt),
    .ready_o (enc_ready),
    .v_o     (pkt_v),
    .data_o  (pkt_q),
    .ready_i (pkt_ready)
  );

  wh_flit_serializer u_serializer (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .v_i         (pkt_v),
    .pkt_i       (pkt_q),
    .ready_o     (pkt_ready),
    .flit_v_o    (flit_v_o),
    .flit_o      (flit_o),
    .flit_ready_i(flit_ready_i)
  );

endmodule

`default_nettype wire

// File: verification/tb_lce_resp_wh_tx.sv
// ----------------------------------------------------------------------
// Testbench for the LCE response transmitter
// Vectors come from verification/lce_resp_vectors.txt, run from the
// project root; flit_ready_i toggles at random to apply back-pressure
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

`include "lce_resp_wh_consts.svh"

module tb_lce_resp_wh_tx;

  import lce_resp_pkg::*;

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 16;
  localparam int NUM_VECS       = 16;
  localparam int CYCLES_PER_VEC = 40;
  localparam int DRAIN_CYCLES   = 20;  // Idle time to catch extra flits
  localparam int VEC_WIDTH      = 320;
  localparam int MAX_FLITS      = ($bits(wh_packet_s) + `FLIT_WIDTH - 1) / `FLIT_WIDTH;
  localparam int PAD_WIDTH      = MAX_FLITS * `FLIT_WIDTH;
  localparam int TIMEOUT_NS     = (RESET_CYCLES + NUM_VECS * CYCLES_PER_VEC) * CLK_PERIOD;

  logic                    clk_i;
  logic                    arst_n_i;
  logic                    msg_v_i;
  lce_resp_msg_s           msg_i;
  logic                    msg_ready_o;
  logic                    flit_v_o;
  logic [`FLIT_WIDTH-1:0]  flit_o;
  logic                    flit_ready_i;

  logic [VEC_WIDTH-1:0] vec_mem [0:NUM_VECS-1];
  integer               seed = 32'h8412_1dd9;
  int                   checks;
  int                   errors;
  int                   total_flits;  // Every output handshake, seen or not by the monitor
  int                   exp_total;

  lce_resp_wh_tx lce_resp_wh_tx_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .msg_v_i     (msg_v_i),
    .msg_i       (msg_i),
    .msg_ready_o (msg_ready_o),
    .flit_v_o    (flit_v_o),
    .flit_o      (flit_o),
    .flit_ready_i(flit_ready_i)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Output is ready about three cycles in four
  always @(posedge clk_i) begin
    #2;
    flit_ready_i = (($random(seed) % 4) != 0);
  end

  always @(posedge clk_i) begin
    if (arst_n_i && flit_v_o && flit_ready_i) total_flits++;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Vector layout from the top: type, size, addr, src, dst, y, x, cid, len, data
  function automatic lce_resp_hdr_s vec_hdr(input logic [VEC_WIDTH-1:0] vec);
    lce_resp_hdr_s hdr;
    hdr.msg_type = resp_msg_type_e'(vec[318:316]);
    hdr.size     = msg_size_e'(vec[314:312]);
    hdr.addr     = vec[311:280];
    hdr.src_id   = vec[279:276];
    hdr.dst_id   = vec[275:272];
    return hdr;
  endfunction

  function automatic logic [`BLOCK_WIDTH-1:0] keep_low_bytes(
      input logic [`BLOCK_WIDTH-1:0] data, input int nbytes);
    logic [`BLOCK_WIDTH-1:0] kept;
    kept = '0;
    for (int b = 0; b < nbytes; b++) begin
      kept[b*8 +: 8] = data[b*8 +: 8];
    end
    return kept;
  endfunction

  // Whole packet as the flits should carry it, zero padded to full flits
  function automatic logic [PAD_WIDTH-1:0] expected_packet(input logic [VEC_WIDTH-1:0] vec);
    wh_packet_s pkt;
    int         nbytes;
    pkt                = '0;
    pkt.wh_hdr.cord.y  = vec[270:268];
    pkt.wh_hdr.cord.x  = vec[266:264];
    pkt.wh_hdr.cid     = vec[261:260];
    pkt.wh_hdr.len     = vec[259:256];
    pkt.msg_hdr        = vec_hdr(vec);
    nbytes = (pkt.msg_hdr.msg_type == e_wb) ? (1 << pkt.msg_hdr.size) : 0;
    pkt.data           = keep_low_bytes(vec[255:0], nbytes);
    return PAD_WIDTH'(pkt);
  endfunction

  // ----------------------------------------------------------------------
  // Driver and monitor
  // ----------------------------------------------------------------------
  task automatic send_msgs();
    #2;
    for (int v = 0; v < NUM_VECS; v++) begin
      msg_i.hdr  = vec_hdr(vec_mem[v]);
      msg_i.data = vec_mem[v][255:0];  // Raw data, bytes above the size included
      msg_v_i    = 1'b1;
      do @(posedge clk_i); while (!msg_ready_o);
      #2;
    end
    msg_v_i = 1'b0;
  endtask

  task automatic watch_flits();
    logic [PAD_WIDTH-1:0] exp_bits;
    wh_hdr_s              got_hdr;
    int                   len;
    for (int v = 0; v < NUM_VECS; v++) begin
      exp_bits = expected_packet(vec_mem[v]);
      len      = int'(vec_mem[v][259:256]);
      for (int k = 0; k <= len; k++) begin
        do @(posedge clk_i); while (!(flit_v_o && flit_ready_i));
        if (k == 0) begin
          got_hdr = flit_o[11:0];
          check_value($sformatf("vec%0d cord", v),
                      64'({vec_mem[v][270:268], vec_mem[v][266:264]}), 64'(got_hdr.cord));
          check_value($sformatf("vec%0d cid", v), 64'(vec_mem[v][261:260]), 64'(got_hdr.cid));
          check_value($sformatf("vec%0d len", v), 64'(vec_mem[v][259:256]), 64'(got_hdr.len));
        end
        check_value($sformatf("vec%0d flit%0d", v, k), exp_bits[k*`FLIT_WIDTH +: `FLIT_WIDTH],
                    flit_o);
      end
    end
  endtask

  initial begin
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    msg_v_i      = 1'b0;
    msg_i        = '0;
    flit_ready_i = 1'b0;
    checks       = 0;
    errors       = 0;
    total_flits  = 0;
    exp_total    = 0;
    $readmemh("verification/lce_resp_vectors.txt", vec_mem);
    for (int v = 0; v < NUM_VECS; v++) begin
      exp_total += int'(vec_mem[v][259:256]) + 1;
    end

    repeat (RESET_CYCLES) @(posedge clk_i);
    #2 arst_n_i = 1'b1;
    @(posedge clk_i);
    check_value("idle flit_v_o", 64'(1'b0), 64'(flit_v_o));
    check_value("idle msg_ready_o", 64'(1'b1), 64'(msg_ready_o));

    fork
      send_msgs();
      watch_flits();
    join
    repeat (DRAIN_CYCLES) @(posedge clk_i);
    check_value("total flits", 64'(exp_total), 64'(total_flits));

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns with %0d of %0d flits transferred",
             TIMEOUT_NS, total_flits, exp_total);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verilog
verilog/lce_resp_wh_pkg.sv
verilog/wh_pipe_reg.sv
verilog/lce_resp_wh_encode.sv
verilog/wh_flit_serializer.sv
verilog/lce_resp_wh_tx.sv
verification/tb_lce_resp_wh_tx.sv

// File: run_sim.sh
#!/bin/sh
# Builds the LCE response transmitter testbench with Verilator and runs it.
# The run counts as passed only if the log holds the pass line.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  -f tb.f \
  --top-module tb_lce_resp_wh_tx \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^No errors$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// File: verification/lce_resp_vectors.txt
// type_size_addr_src_dst_y_x_cid_len_data, addr has 8 hex digits, data 64, others 1 each
// y, x, cid and len are the expected wormhole header fields for the response
0_0_80000040_1_0_0_0_0_0_ffeeddcc_bbaa9988_77665544_33221100_0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0
1_0_80001000_2_5_1_1_0_0_13579bdf_02468ace_fdb97531_eca86420_11112222_33334444_55556666_77778888
2_0_12345678_3_a_0_2_1_0_a5a5a5a5_5a5a5a5a_c3c3c3c3_3c3c3c3c_96969696_69696969_0ff00ff0_f00ff00f
4_3_0000ff80_4_f_1_3_1_0_deadbeef_cafef00d_01234567_89abcdef_fedcba98_76543210_a5a55a5a_12345678
3_0_00000100_5_3_0_3_0_1_11223344_55667788_99aabbcc_ddeeff00_12121212_34343434_56565656_789abcde
3_1_00000204_6_6_1_2_0_1_87654321_0fedcba9_13243546_57687980_a1b2c3d4_e5f60718_293a4b5c_6d7e8f90
3_2_00000408_7_9_0_1_1_1_cafebabe_8badf00d_feedface_c0ffee00_facefeed_0badcafe_beefbeef_1337c0de
3_3_00000810_8_c_1_0_1_1_0123abcd_4567ef01_89ab2345_cdef6789_fedc0123_ba984567_76548901_3210cdef
3_4_00001020_9_7_1_3_0_2_5555aaaa_aaaa5555_3333cccc_cccc3333_0f0f0f0f_f0f0f0f0_00ff00ff_ff00ff00
3_5_00002040_a_e_1_2_1_4_00010203_04050607_08090a0b_0c0d0e0f_10111213_14151617_18191a1b_1c1d1e1f
3_5_00004080_b_0_0_0_0_4_f1e2d3c4_b5a69788_79605a4b_3c2d1e0f_a0b1c2d3_e4f50617_28394a5b_6c7d8e9f
3_4_00008100_c_b_0_3_1_2_9abcdef0_12345678_0fedcba9_87654321_aaaa0000_bbbb1111_cccc2222_dddd3333
0_0_c0000000_d_d_1_1_1_0_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff
3_0_00010000_e_8_0_0_1_1_77777777_66666666_55555555_44444444_33333333_22222222_11111111_000000a5
3_5_00020000_f_4_1_0_0_4_2468ace0_13579bdf_eca86420_fdb97531_c0c0c0c0_d1d1d1d1_e2e2e2e2_f3f3f3f3
1_0_00040000_0_2_0_2_0_0_89898989_abababab_cdcdcdcd_efefefef_01010101_23232323_45454545_67676767
